// ==== verilog/l2_ctrl_pkg.sv ====
/* L2 cache controller types */

package l2_ctrl_pkg;

    // four-way set associative
    localparam int NUM_WAYS  = 4;
    localparam int WAY_IDX_W = 2;
    // tree pseudo-LRU, one bit per internal node
    localparam int PLRU_W    = 3;

    typedef logic [WAY_IDX_W-1:0] way_idx_t;
    typedef logic [NUM_WAYS-1:0]  way_vec_t;

    // bit 2: 0 -> victim in ways 2-3, 1 -> victim in ways 0-1
    // bit 1: 0 -> victim way 1, 1 -> victim way 0
    // bit 0: 0 -> victim way 3, 1 -> victim way 2
    typedef logic [PLRU_W-1:0] plru_t;

    // per-way data array write source
    typedef enum logic [1:0] {
        src_none = 2'b00,
        src_cpu  = 2'b01,
        src_mem  = 2'b10
    } data_src_t;

    // physical memory address: requested line or victim line
    typedef enum logic {
        addr_fill  = 1'b0,
        addr_evict = 1'b1
    } pmem_addr_src_t;

    // cpu request levels, held until mem_resp
    typedef struct packed {
        logic read;
        logic write;
    } cpu_req_t;

    // combinational reads of the current set
    typedef struct packed {
        way_vec_t valid;
        way_vec_t dirty;
        way_vec_t hit;
    } way_status_t;

    typedef struct packed {
        logic     hit;
        way_idx_t hit_way;
        way_idx_t victim_way;
        // victim valid and dirty, needs write-back
        logic     victim_dirty;
        plru_t    plru_on_hit;
    } way_decode_t;

    // one action per cycle from the FSM to array control
    typedef enum logic [1:0] {
        act_none   = 2'b00,
        act_access = 2'b01,
        act_evict  = 2'b10,
        act_fill   = 2'b11
    } ctrl_action_t;

    // per-way strobes into tag, valid, dirty and data arrays
    typedef struct packed {
        way_vec_t                 tag_load;
        way_vec_t                 valid_load;
        way_vec_t                 valid_in;
        way_vec_t                 dirty_load;
        way_vec_t                 dirty_in;
        data_src_t [NUM_WAYS-1:0] data_src;
    } array_ctrl_t;

endpackage

// ==== verilog/l2_way_decode.sv ====
/* Way and victim decode */

`timescale 1ns/1ps

module l2_way_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  l2_ctrl_pkg::way_status_t  status,
    input  l2_ctrl_pkg::plru_t        plru,
    output l2_ctrl_pkg::way_decode_t  dec
);

    // lowest set bit of a way vector, zero when empty
    function automatic l2_ctrl_pkg::way_idx_t first_set(input l2_ctrl_pkg::way_vec_t vec);
        l2_ctrl_pkg::way_idx_t idx;
        idx = '0;
        // scan downward so the lowest way wins
        for (int i = l2_ctrl_pkg::NUM_WAYS - 1; i >= 0; i--)
        begin
            if (vec[i])
            begin
                idx = l2_ctrl_pkg::way_idx_t'(i);
            end
        end
        return idx;
    endfunction

    l2_ctrl_pkg::way_idx_t plru_way;
    logic                  any_invalid;

    // way the tree points away from
    always_comb
    begin
        if (plru[2])
        begin
            plru_way = plru[1] ? 2'd0 : 2'd1;
        end
        else
        begin
            plru_way = plru[0] ? 2'd2 : 2'd3;
        end
    end

    assign any_invalid = ~&status.valid;

    always_comb
    begin
        dec.hit     = |status.hit;
        dec.hit_way = first_set(status.hit);

        // invalid ways first, then pseudo-LRU
        dec.victim_way   = any_invalid ? first_set(~status.valid) : plru_way;
        dec.victim_dirty = status.valid[dec.victim_way] & status.dirty[dec.victim_way];

        // point the tree away from the hit way
        case (dec.hit_way)
            2'd0:    dec.plru_on_hit = {1'b0, 1'b0, plru[0]};
            2'd1:    dec.plru_on_hit = {1'b0, 1'b1, plru[0]};
            2'd2:    dec.plru_on_hit = {1'b1, plru[1], 1'b0};
            default: dec.plru_on_hit = {1'b1, plru[1], 1'b1};
        endcase
    end

    // a tag sits in at most one way of the set
    hit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(status.hit)
    );

endmodule

// ==== verilog/l2_ctrl_fsm.sv ====
/* L2 controller state machine */

`timescale 1ns/1ps

module l2_ctrl_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  l2_ctrl_pkg::cpu_req_t        req,
    input  l2_ctrl_pkg::way_decode_t     dec,
    input  logic                         ewb_hit,
    input  logic                         pmem_resp,
    output l2_ctrl_pkg::ctrl_action_t    action,
    output logic                         mem_resp,
    output logic                         pmem_read,
    output l2_ctrl_pkg::pmem_addr_src_t  pmem_addr_src
);

    typedef enum logic [1:0] {
        s_idle,
        s_access,
        s_write_back,
        s_fill
    } state_t;

    state_t state;
    state_t next_state;

    logic req_any;
    logic serve;
    logic bypass;

    assign req_any = req.read | req.write;
    // hit in the set, or read satisfied from the EWB
    assign serve   = dec.hit | (req.read & ewb_hit);
    // write miss whose line is still in the EWB, no memory read
    assign bypass  = req.write & ewb_hit;

    always_comb
    begin
        next_state    = state;
        action        = l2_ctrl_pkg::act_none;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_addr_src = l2_ctrl_pkg::addr_fill;

        case (state)
            s_idle:
            begin
                if (req_any)
                begin
                    next_state = s_access;
                end
            end

            s_access:
            begin
                action = l2_ctrl_pkg::act_access;
                if (serve)
                begin
                    mem_resp   = req_any;
                    next_state = s_idle;
                end
                else if (dec.victim_dirty)
                begin
                    next_state = s_write_back;
                end
                else
                begin
                    next_state = s_fill;
                end
            end

            // single cycle, victim line into the EWB
            s_write_back:
            begin
                action        = l2_ctrl_pkg::act_evict;
                pmem_addr_src = l2_ctrl_pkg::addr_evict;
                next_state    = s_fill;
            end

            s_fill:
            begin
                pmem_read = ~bypass;
                // fill cycle, then retry the access
                if (pmem_resp | bypass)
                begin
                    action     = l2_ctrl_pkg::act_fill;
                    next_state = s_access;
                end
            end

            default:
            begin
                next_state = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= s_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    // cpu holds its request while the controller works on it
    req_held: assert property (
        @(posedge clk) disable iff (rst)
        (state != s_idle) |-> (req.read || req.write)
    );

    // memory read held until memory answers
    pmem_read_held: assert property (
        @(posedge clk) disable iff (rst)
        (pmem_read && !pmem_resp) |=> pmem_read
    );

endmodule

// ==== verilog/l2_array_ctrl.sv ====
/* Per-way array control */

`timescale 1ns/1ps

module l2_array_ctrl (
    input  l2_ctrl_pkg::cpu_req_t      req,
    input  l2_ctrl_pkg::ctrl_action_t  action,
    input  l2_ctrl_pkg::way_decode_t   dec,
    output l2_ctrl_pkg::array_ctrl_t   arr,
    output logic                       plru_load,
    output l2_ctrl_pkg::plru_t         plru_next,
    output l2_ctrl_pkg::way_idx_t      dataout_sel,
    output logic                       load_ewb
);

    l2_ctrl_pkg::way_vec_t hit_sel;
    l2_ctrl_pkg::way_vec_t victim_sel;

    // one-hot way selects
    assign hit_sel    = l2_ctrl_pkg::way_vec_t'(1) << dec.hit_way;
    assign victim_sel = l2_ctrl_pkg::way_vec_t'(1) << dec.victim_way;

    // LRU word only matters with plru_load
    assign plru_next = dec.plru_on_hit;

    always_comb
    begin
        arr.tag_load   = '0;
        arr.valid_load = '0;
        arr.valid_in   = '0;
        arr.dirty_load = '0;
        arr.dirty_in   = '0;
        for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
        begin
            arr.data_src[i] = l2_ctrl_pkg::src_none;
        end
        plru_load   = 1'b0;
        dataout_sel = '0;
        load_ewb    = 1'b0;

        case (action)
            l2_ctrl_pkg::act_access:
            begin
                if (dec.hit)
                begin
                    plru_load = 1'b1;
                    if (req.read)
                    begin
                        dataout_sel = dec.hit_way;
                    end
                    else if (req.write)
                    begin
                        // cpu data into the hit way, mark it dirty
                        arr.data_src[dec.hit_way] = l2_ctrl_pkg::src_cpu;
                        arr.dirty_load            = hit_sel;
                        arr.dirty_in              = hit_sel;
                    end
                end
            end

            l2_ctrl_pkg::act_evict:
            begin
                // victim line out to the EWB and invalidated
                load_ewb       = 1'b1;
                dataout_sel    = dec.victim_way;
                arr.valid_load = victim_sel;
            end

            l2_ctrl_pkg::act_fill:
            begin
                // new line, valid and clean
                arr.tag_load                 = victim_sel;
                arr.valid_load               = victim_sel;
                arr.valid_in                 = victim_sel;
                arr.dirty_load               = victim_sel;
                arr.data_src[dec.victim_way] = l2_ctrl_pkg::src_mem;
            end

            default:
            begin
                plru_load = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/l2_ctrl_top.sv ====
/* L2 cache controller top */

`timescale 1ns/1ps

module l2_ctrl_top (
    input  logic                         clk,
    input  logic                         rst,
    // cpu side
    input  l2_ctrl_pkg::cpu_req_t        req,
    output logic                         mem_resp,
    // memory side
    input  logic                         pmem_resp,
    output logic                         pmem_read,
    output l2_ctrl_pkg::pmem_addr_src_t  pmem_addr_src,
    // datapath status, current set
    input  l2_ctrl_pkg::way_status_t     status,
    input  l2_ctrl_pkg::plru_t           plru,
    input  logic                         ewb_hit,
    // datapath control
    output l2_ctrl_pkg::array_ctrl_t     arr,
    output logic                         plru_load,
    output l2_ctrl_pkg::plru_t           plru_next,
    output l2_ctrl_pkg::way_idx_t        dataout_sel,
    output logic                         load_ewb
);

    l2_ctrl_pkg::way_decode_t  dec;
    l2_ctrl_pkg::ctrl_action_t action;

    l2_way_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .status (status),
        .plru   (plru),
        .dec    (dec)
    );

    l2_ctrl_fsm u_fsm (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .dec           (dec),
        .ewb_hit       (ewb_hit),
        .pmem_resp     (pmem_resp),
        .action        (action),
        .mem_resp      (mem_resp),
        .pmem_read     (pmem_read),
        .pmem_addr_src (pmem_addr_src)
    );

    l2_array_ctrl u_array (
        .req         (req),
        .action      (action),
        .dec         (dec),
        .arr         (arr),
        .plru_load   (plru_load),
        .plru_next   (plru_next),
        .dataout_sel (dataout_sel),
        .load_ewb    (load_ewb)
    );

endmodule

// ==== verif/tb_l2_ctrl_checks.svh ====
/* L2 controller checks and reference rules */

int check_count = 0;
int error_count = 0;

// reference set, advanced by the replacement and LRU rules
logic [7:0]            ref_tag [l2_ctrl_pkg::NUM_WAYS];
l2_ctrl_pkg::way_vec_t ref_valid = '0;
l2_ctrl_pkg::way_vec_t ref_dirty = '0;
l2_ctrl_pkg::plru_t    ref_plru  = '0;
// tags written back so far
logic [7:0]            ref_ewb [$];

// fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one compare, values in hex on a mismatch
task automatic record_compare(input string name, input logic same,
                              input logic [63:0] got, input logic [63:0] want);
    check_count++;
    if (!same)
    begin
        error_count++;
        $display("Mismatch %s: got %0h expected %0h", name, got, want);
    end
endtask

// timing and count conditions of one request
task automatic expect_true(input logic ok, input string what);
    check_count++;
    if (!ok)
    begin
        error_count++;
        $display("%s", what);
    end
endtask

task automatic check_way(input string name, input l2_ctrl_pkg::way_idx_t got,
                         input l2_ctrl_pkg::way_idx_t want);
    record_compare(name, got === want, {62'd0, got}, {62'd0, want});
endtask

task automatic check_plru(input string name, input l2_ctrl_pkg::plru_t got,
                          input l2_ctrl_pkg::plru_t want);
    record_compare(name, got === want, {61'd0, got}, {61'd0, want});
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    record_compare(name, got === want, {63'd0, got}, {63'd0, want});
endtask

task automatic check_addr_src(input string name, input l2_ctrl_pkg::pmem_addr_src_t got,
                              input l2_ctrl_pkg::pmem_addr_src_t want);
    record_compare(name, got === want, {63'd0, got}, {63'd0, want});
endtask

task automatic check_ctrl(input string name, input l2_ctrl_pkg::array_ctrl_t got,
                          input l2_ctrl_pkg::array_ctrl_t want);
    record_compare(name, got === want, {36'd0, got}, {36'd0, want});
endtask

// lowest invalid way, else the way the tree points away from
function automatic l2_ctrl_pkg::way_idx_t replace_way(input l2_ctrl_pkg::way_vec_t valid,
                                                      input l2_ctrl_pkg::plru_t p);
    logic                  found;
    l2_ctrl_pkg::way_idx_t w;
    found = 1'b0;
    // upper index bit is the half, lower bit the way in it
    w     = {~p[2], (p[2] ? ~p[1] : ~p[0])};
    for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
    begin
        if (!valid[i] && !found)
        begin
            found = 1'b1;
            w     = l2_ctrl_pkg::way_idx_t'(i);
        end
    end
    return w;
endfunction

// root bit points to the other half, node bit to the other way
function automatic l2_ctrl_pkg::plru_t plru_after_hit(input l2_ctrl_pkg::plru_t p,
                                                      input l2_ctrl_pkg::way_idx_t w);
    l2_ctrl_pkg::plru_t q;
    q = p;
    q[2] = w[1];
    if (w[1])
        q[0] = w[0];
    else
        q[1] = w[0];
    return q;
endfunction

// expected outcome of one request, reference set updated
task automatic predict(input logic wr, input logic [7:0] tag, output test_t t);
    logic                  hit;
    logic                  in_ewb;
    l2_ctrl_pkg::way_idx_t w;
    hit    = 1'b0;
    in_ewb = 1'b0;
    w      = '0;
    for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
    begin
        if (ref_valid[i] && ref_tag[i] == tag)
        begin
            hit = 1'b1;
            w   = l2_ctrl_pkg::way_idx_t'(i);
        end
    end
    foreach (ref_ewb[k])
        if (ref_ewb[k] == tag)
            in_ewb = 1'b1;
    t            = '0;
    t.wr         = wr;
    t.tag        = tag;
    t.exp_direct = hit | (~wr & in_ewb);
    t.exp_plru   = ref_plru;
    // a read served from the EWB leaves the set alone
    if (hit || !t.exp_direct)
    begin
        if (!hit)
        begin
            w          = replace_way(ref_valid, ref_plru);
            t.exp_wb   = ref_valid[w] & ref_dirty[w];
            // write miss on an EWB line skips memory
            t.exp_pmem = ~(wr & in_ewb);
            if (t.exp_wb)
                ref_ewb.push_back(ref_tag[w]);
            ref_tag[w]   = tag;
            ref_valid[w] = 1'b1;
            ref_dirty[w] = 1'b0;
        end
        if (wr)
            ref_dirty[w] = 1'b1;
        ref_plru    = plru_after_hit(ref_plru, w);
        t.exp_held  = 1'b1;
        t.exp_way   = w;
        t.exp_dirty = ref_dirty[w];
        t.exp_plru  = ref_plru;
    end
endtask

// ==== verif/tb_l2_ctrl.sv ====
/* L2 controller testbench */

`timescale 1ns/1ps

module tb_l2_ctrl;

    localparam int NUM_TESTS   = 16;
    localparam int WATCHDOG_NS = NUM_TESTS * 16 * 20;

    // {write, tag} per request, in order
    localparam logic [8:0] STIM [NUM_TESTS] = '{
        // cold misses fill ways 0 to 3
        9'h0a0, 9'h0a1, 9'h0a2, 9'h0a3,
        // read hit, then write hits on ways 2 and 0
        9'h0a1, 9'h1a2, 9'h1a0,
        // full set, clean, clean, then dirty victim
        9'h0b0, 9'h1b1, 9'h0b2,
        // EWB read, EWB write bypass, EWB read
        9'h0a2, 9'h1a2, 9'h0a0,
        // hit, dirty victim, read of the line just evicted
        9'h0b0, 9'h1b3, 9'h0b1
    };

    typedef struct packed {
        logic                  wr;
        logic [7:0]            tag;
        // served in ACCESS without a fill
        logic                  exp_direct;
        logic                  exp_held;
        l2_ctrl_pkg::way_idx_t exp_way;
        logic                  exp_dirty;
        logic                  exp_wb;
        logic                  exp_pmem;
        l2_ctrl_pkg::plru_t    exp_plru;
    } test_t;

    logic                        clk = 1'b0;
    logic                        rst = 1'b1;
    l2_ctrl_pkg::cpu_req_t       req = '0;
    logic [7:0]                  cur_tag = '0;
    logic                        pmem_resp = 1'b0;
    logic                        mem_resp;
    logic                        pmem_read;
    l2_ctrl_pkg::pmem_addr_src_t pmem_addr_src;
    l2_ctrl_pkg::way_status_t    status;
    logic                        ewb_hit;
    l2_ctrl_pkg::array_ctrl_t    arr;
    logic                        plru_load;
    l2_ctrl_pkg::plru_t          plru_next;
    l2_ctrl_pkg::way_idx_t       dataout_sel;
    logic                        load_ewb;

    // one-set model, moved only by DUT strobes
    logic [7:0]                  mdl_tag [l2_ctrl_pkg::NUM_WAYS];
    l2_ctrl_pkg::way_vec_t       mdl_valid = '0;
    l2_ctrl_pkg::way_vec_t       mdl_dirty = '0;
    l2_ctrl_pkg::plru_t          plru = '0;
    logic [7:0]                  ewb_tag [l2_ctrl_pkg::NUM_WAYS];
    logic [3:0]                  ewb_vld = '0;
    logic [1:0]                  ewb_ptr = '0;
    // memory delay source
    logic [15:0]                 lfsr_state = 16'd15365;
    logic [1:0]                  delay_bits = '0;
    logic [2:0]                  wait_cnt = '0;
    logic                        mem_busy = 1'b0;
    test_t                       tests [NUM_TESTS];

    `include "tb_l2_ctrl_checks.svh"

    always #10 clk = ~clk;

    l2_ctrl_top u_l2_ctrl_top (.*);

    // set status and EWB lookup for the current tag
    always_comb
    begin
        status.valid = mdl_valid;
        status.dirty = mdl_dirty;
        ewb_hit      = 1'b0;
        for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
        begin
            status.hit[i] = (req.read | req.write) & mdl_valid[i] & (mdl_tag[i] == cur_tag);
            ewb_hit      |= (req.read | req.write) & ewb_vld[i] & (ewb_tag[i] == cur_tag);
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            mdl_valid <= '0;
            mdl_dirty <= '0;
            plru      <= '0;
            ewb_vld   <= '0;
            ewb_ptr   <= '0;
        end
        else
        begin
            for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
            begin
                if (arr.tag_load[i])
                    mdl_tag[i] <= cur_tag;
                if (arr.valid_load[i])
                    mdl_valid[i] <= arr.valid_in[i];
                if (arr.dirty_load[i])
                    mdl_dirty[i] <= arr.dirty_in[i];
            end
            if (plru_load)
                plru <= plru_next;
            // victim tag captured by the EWB
            if (load_ewb)
            begin
                ewb_tag[ewb_ptr] <= mdl_tag[dataout_sel];
                ewb_vld[ewb_ptr] <= 1'b1;
                ewb_ptr          <= ewb_ptr + 2'd1;
            end
        end
    end

    // memory answers a read after 1 to 4 cycles
    always @(posedge clk)
    begin
        if (rst | pmem_resp)
        begin
            pmem_resp <= 1'b0;
            mem_busy  <= 1'b0;
        end
        else if (mem_busy)
        begin
            if (wait_cnt <= 3'd1)
                pmem_resp <= 1'b1;
            else
                wait_cnt <= wait_cnt - 3'd1;
        end
        else if (pmem_read)
        begin
            // one LFSR step per delay bit
            lfsr_state    = lfsr_step(lfsr_state);
            delay_bits[0] = lfsr_state[0];
            lfsr_state    = lfsr_step(lfsr_state);
            delay_bits[1] = lfsr_state[0];
            wait_cnt <= {1'b0, delay_bits} + 3'd1;
            mem_busy <= 1'b1;
        end
    end

    task automatic run_test(input int n);
        int                       cycles;
        int                       evicts;
        int                       errs_before;
        logic                     pmem_seen;
        logic                     found;
        l2_ctrl_pkg::way_idx_t    evict_way;
        l2_ctrl_pkg::way_idx_t    resp_sel;
        l2_ctrl_pkg::way_idx_t    held_way;
        l2_ctrl_pkg::array_ctrl_t resp_arr;
        l2_ctrl_pkg::array_ctrl_t exp_arr;
        test_t                    t;
        t           = tests[n];
        cycles      = 0;
        evicts      = 0;
        errs_before = error_count;
        pmem_seen   = 1'b0;
        evict_way   = '0;
        cur_tag   <= t.tag;
        req.read  <= ~t.wr;
        req.write <= t.wr;
        // until mem_resp, noting evictions and memory reads
        do
        begin
            @(posedge clk);
            cycles++;
            if (load_ewb)
            begin
                evicts++;
                evict_way = dataout_sel;
                // write-back goes to the victim line address
                check_addr_src("pmem_addr_src", pmem_addr_src, l2_ctrl_pkg::addr_evict);
            end
            if (pmem_read)
            begin
                pmem_seen = 1'b1;
                check_addr_src("pmem_addr_src", pmem_addr_src, l2_ctrl_pkg::addr_fill);
            end
        end while (!mem_resp);
        resp_arr = arr;
        resp_sel = dataout_sel;
        req <= '0;
        // write hit marks only its way dirty, cpu data in
        exp_arr = '0;
        if (t.wr)
        begin
            exp_arr.dirty_load[t.exp_way] = 1'b1;
            exp_arr.dirty_in[t.exp_way]   = 1'b1;
            exp_arr.data_src[t.exp_way]   = l2_ctrl_pkg::src_cpu;
        end
        check_ctrl("arr", resp_arr, exp_arr);
        if (!t.wr && t.exp_held)
            check_way("dataout_sel", resp_sel, t.exp_way);
        if (t.exp_direct)
            expect_true(cycles == 2,
                        $sformatf("response came after %0d cycles, not on the second", cycles));
        check_flag("write_back", evicts != 0, t.exp_wb);
        expect_true(evicts <= 1,
                    $sformatf("load_ewb was high for %0d cycles in one request", evicts));
        if (t.exp_wb)
            check_way("evict_way", evict_way, t.exp_way);
        check_flag("pmem_read", pmem_seen, t.exp_pmem);
        // model now holds the response cycle's updates
        @(posedge clk);
        found    = 1'b0;
        held_way = '0;
        for (int i = 0; i < l2_ctrl_pkg::NUM_WAYS; i++)
        begin
            if (mdl_valid[i] && mdl_tag[i] == t.tag)
            begin
                found    = 1'b1;
                held_way = l2_ctrl_pkg::way_idx_t'(i);
            end
        end
        check_flag("tag_held", found, t.exp_held);
        if (found && t.exp_held)
        begin
            check_way("held_way", held_way, t.exp_way);
            check_flag("line_dirty", mdl_dirty[held_way], t.exp_dirty);
        end
        check_plru("plru", plru, t.exp_plru);
        $display("test %0d %s %h: %s", n + 1, t.wr ? "write" : "read", t.tag,
                 (error_count == errs_before) ? "ok" : "bad");
    endtask

    initial
    begin
        int errs_before;
        for (int n = 0; n < NUM_TESTS; n++)
            predict(STIM[n][8], STIM[n][7:0], tests[n]);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        errs_before = error_count;
        // quiet outputs until the first request
        repeat (2)
        begin
            @(posedge clk);
            check_flag("mem_resp", mem_resp, 1'b0);
            check_flag("pmem_read", pmem_read, 1'b0);
            check_flag("load_ewb", load_ewb, 1'b0);
            check_flag("plru_load", plru_load, 1'b0);
            check_ctrl("arr", arr, '0);
        end
        $display("reset idle: %s", (error_count == errs_before) ? "ok" : "bad");
        for (int n = 0; n < NUM_TESTS; n++)
            run_test(n);
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, check_count, error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // bound on the whole run
    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a response never came", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verif
verilog/l2_ctrl_pkg.sv
verilog/l2_way_decode.sv
verilog/l2_ctrl_fsm.sv
verilog/l2_array_ctrl.sv
verilog/l2_ctrl_top.sv
verif/tb_l2_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the L2 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_l2_ctrl \
    -Mdir obj_dir -o tb_l2_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_l2_ctrl > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
